// File: project.f
+incdir+tests
hdl/snd_pkg.sv
hdl/prog_fetch.sv
hdl/instr_decode.sv
hdl/exec_unit.sv
hdl/snd_cpu_top.sv
tests/snd_cpu_assert.sv
tests/snd_cpu_tb.sv

// File: Makefile
# Verilator flow for the sound cpu testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= snd_cpu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides the result, the binary may stop early on an assertion
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/snd_cpu_model.svh
// instruction-level reference model of the sound cpu
// fills exp_q with the port B values a program should produce
`ifndef SND_CPU_MODEL_SVH
`define SND_CPU_MODEL_SVH

task automatic model_program(input logic [data_w-1:0] pa_val);
  logic [data_w-1:0]  acc;
  logic [data_w-1:0]  regs [reg_num];
  logic [rom_aw-1:0]  pc;
  logic [rom_aw-1:0]  pc_next;
  logic [instr_w-1:0] word;
  logic [data_w-1:0]  n;
  logic [reg_aw-1:0]  r;
  op_e                op;
  logic               skip;
  logic               done;
  int                 steps;
  acc   = '0;
  pc    = '0;
  skip  = 1'b0;
  done  = 1'b0;
  steps = 0;
  foreach (regs[i]) regs[i] = '0;
  exp_q.delete();
  while (!done && steps < 4 * rom_depth) begin
    word    = prog_mem[pc];
    n       = word[7:0];
    r       = word[11:8];
    op      = (word[15:12] > 4'd13) ? nop : op_e'(word[15:12]);  // 14 and 15 act as nop
    pc_next = pc + rom_aw'(1);
    steps++;
    if (skip) begin
      skip = 1'b0;                      // this slot is dropped
    end else begin
      case (op)
        mvi_a:   acc = n;
        mvi_r:   regs[r] = n;
        mov_a_r: acc = regs[r];
        mov_r_a: regs[r] = acc;
        adi: begin
          skip = ({1'b0, acc} + {1'b0, n}) > 9'd255;  // carry out
          acc  = acc + n;
        end
        sbi: begin
          skip = (acc < n);             // borrow
          acc  = acc - n;
        end
        andi: begin
          acc  = acc & n;
          skip = (acc == '0);
        end
        ori:     acc = acc | n;
        xori:    acc = acc ^ n;
        add_r:   acc = acc + regs[r];
        in_pa:   acc = pa_val;
        out_pb:  exp_q.push_back(acc);
        jmp: begin
          if (word[8:0] == pc) done = 1'b1;  // end of program loop
          pc_next = word[8:0];
        end
        default: ;
      endcase
    end
    pc = pc_next;
  end
endtask

`endif

// File: tests/snd_cpu_tb.sv
// testbench for the sound cpu with random programs,
// reference model, pb checks and watchdog
`timescale 1ns/1ps

module snd_cpu_tb
  import snd_pkg::*;
();

  localparam int n_programs = 20;
  localparam int max_len    = 122;     // 120 random words and two end loops
  localparam int rst_cycles = 16;
  localparam int clk_period = 10;
  localparam int seed       = 64713;
  localparam int wd_cycles  = n_programs * (rst_cycles + 4 * max_len + 32);

  logic               CLK;
  logic               rst;
  logic               prog_we;
  logic [rom_aw-1:0]  prog_addr;
  logic [instr_w-1:0] prog_data;
  logic [data_w-1:0]  pa;
  logic [data_w-1:0]  pb;
  logic               pb_strobe;

  logic [instr_w-1:0] prog_mem [rom_depth];
  int unsigned        prog_len;
  logic [data_w-1:0]  pa_val;
  logic [data_w-1:0]  exp_q [$];       // expected pb values in order
  int                 got_count;
  int                 val_errs = 0;
  int                 cnt_errs = 0;
  logic               was_rst  = 1'b1;

  `include "snd_cpu_model.svh"

  snd_cpu_top snd_cpu_top_i (
    .CLK       (CLK),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pa        (pa),
    .pb        (pb),
    .pb_strobe (pb_strobe)
  );

  initial begin
    CLK = 1'b0;
    forever #(clk_period / 2) CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_pb(input logic [data_w-1:0] data, input logic [data_w-1:0] expected);
    if (data !== expected) begin
      val_errs++;
      $display("FAIL pb at %0t: got 0x%02h expected 0x%02h", $time, data, expected);
    end
  endtask

  task automatic check_count(input int got, input int expected);
    if (got < expected) begin
      cnt_errs++;
      $display("missing pb strobes: saw %0d of %0d expected", got, expected);
    end else if (got > expected) begin
      cnt_errs++;
      $display("extra pb strobes: saw %0d where %0d were expected", got, expected);
    end
  endtask

  // sample the registered outputs half a cycle after the edge
  always @(negedge CLK) begin
    if (rst) begin
      got_count = 0;
    end else begin
      if (was_rst) check_pb(pb, '0);   // pb clear out of reset
      if (pb_strobe) begin
        if (got_count < exp_q.size()) check_pb(pb, exp_q[got_count]);
        got_count++;
      end
    end
    was_rst = rst;
  end

  ////////////////////////////////////////////////////////////////////////////
  // program generation, load and run

  task automatic gen_program();
    int unsigned n;
    int unsigned seg;
    int unsigned pos;
    int unsigned hi;
    logic [3:0]  opc;
    n = $urandom_range(120, 40);
    for (int unsigned i = 0; i < n; i++) begin
      opc = 4'($urandom_range(15, 0));
      if (opc == jmp) begin
        hi = (i + 8 < n) ? i + 8 : n;  // short forward hop
        prog_mem[rom_aw'(i)] = {jmp, 3'b000, rom_aw'($urandom_range(hi, i + 1))};
      end else begin
        prog_mem[rom_aw'(i)] = {opc, 12'($urandom_range(4095, 0))};
      end
    end
    seg = n / 8;
    for (int unsigned k = 0; k < 8; k++) begin
      pos = k * seg + $urandom_range(seg - 1, 0);
      prog_mem[rom_aw'(pos)] = {out_pb, 12'h000};
    end
    prog_mem[rom_aw'(n)]     = {jmp, 3'b000, rom_aw'(n)};
    prog_mem[rom_aw'(n + 1)] = {jmp, 3'b000, rom_aw'(n + 1)};
    prog_len = n + 2;
  endtask

  task automatic load_program();
    @(posedge CLK);
    rst <= 1'b1;
    pa  <= pa_val;                     // held for the whole run
    for (int unsigned i = 0; i < prog_len; i++) begin
      @(posedge CLK);
      prog_we   <= 1'b1;
      prog_addr <= rom_aw'(i);
      prog_data <= prog_mem[rom_aw'(i)];
    end
    @(posedge CLK);
    prog_we <= 1'b0;
    repeat (rst_cycles - 1) @(posedge CLK);
    rst <= 1'b0;
  endtask

  task automatic run_program();
    int unsigned window;
    int unsigned cycles;
    window = 3 * prog_len + 8;         // one slot per word plus jmp bubbles
    cycles = 0;
    while (got_count < exp_q.size() && cycles < window) begin
      @(posedge CLK);
      cycles++;
    end
    while (cycles < window) begin      // late strobes would be extras
      @(posedge CLK);
      cycles++;
    end
    check_count(got_count, exp_q.size());
  endtask

  initial begin
    rst       <= 1'b1;
    prog_we   <= 1'b0;
    prog_addr <= '0;
    prog_data <= '0;
    pa        <= '0;
    void'($urandom(seed));
    for (int p = 0; p < n_programs; p++) begin
      gen_program();
      pa_val = 8'($urandom_range(255, 0));
      model_program(pa_val);
      load_program();
      run_program();
    end
    $display("errors: %0d pb value, %0d strobe count", val_errs, cnt_errs);
    if (val_errs == 0 && cnt_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(wd_cycles * clk_period);
    $display("watchdog expired after %0d cycles without finishing", wd_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

// File: tests/snd_cpu_assert.sv
// concurrent checks on the execute stage strobes
// bound into exec_unit
`timescale 1ns/1ps

module snd_cpu_assert
  import snd_pkg::*;
(
  input logic      CLK,
  input logic      rst,
  input dec_t      decoded,
  input logic      pb_strobe,
  input redirect_t redirect
);

  // strobe is a register and clears on the first edge of reset
  strobe_in_reset: assert property (@(posedge CLK) rst && $past(rst) |-> !pb_strobe)
    else $error("pb_strobe high while reset is held");

  one_cycle_redirect: assert property (@(posedge CLK) disable iff (rst)
    redirect.valid |=> !redirect.valid)
    else $error("redirect valid on two cycles in a row");

  squash_after_redirect: assert property (@(posedge CLK) disable iff (rst)
    redirect.valid |=> !decoded.valid)
    else $error("decoded instruction valid right after a redirect");

endmodule

bind exec_unit snd_cpu_assert exec_assert_i (
  .CLK       (CLK),
  .rst       (rst),
  .decoded   (decoded),
  .pb_strobe (pb_strobe),
  .redirect  (redirect)
);

// File: hdl/snd_cpu_top.sv
// sound cpu top level wiring the three-stage pipeline of fetch,
// decode and execute to the program and I/O ports
`timescale 1ns/1ps

module snd_cpu_top
  import snd_pkg::*;
(
  input  logic               CLK,
  input  logic               rst,
  input  logic               prog_we,
  input  logic [rom_aw-1:0]  prog_addr,
  input  logic [instr_w-1:0] prog_data,
  input  logic [data_w-1:0]  pa,
  output logic [data_w-1:0]  pb,
  output logic               pb_strobe
);

  fetch_t    fetched;    // fetch to decode
  dec_t      decoded;    // decode to execute
  redirect_t redirect;   // execute back to both earlier stages

  prog_fetch prog_fetch_i (
    .CLK       (CLK),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .redirect  (redirect),
    .fetched   (fetched)
  );

  instr_decode instr_decode_i (
    .CLK      (CLK),
    .rst      (rst),
    .fetched  (fetched),
    .redirect (redirect),
    .decoded  (decoded)
  );

  exec_unit exec_unit_i (
    .CLK       (CLK),
    .rst       (rst),
    .decoded   (decoded),
    .pa        (pa),
    .pb        (pb),
    .pb_strobe (pb_strobe),
    .redirect  (redirect)
  );

endmodule

// File: hdl/exec_unit.sv
// execute stage with accumulator, register file, ALU,
// skip flag, port B register and jump requests
`timescale 1ns/1ps

module exec_unit
  import snd_pkg::*;
(
  input  logic              CLK,
  input  logic              rst,
  input  dec_t              decoded,
  input  logic [data_w-1:0] pa,
  output logic [data_w-1:0] pb,
  output logic              pb_strobe,
  output redirect_t         redirect
);

  logic [data_w-1:0]              a;
  logic [reg_num-1:0][data_w-1:0] rf;         // Rr from the on-chip SRAM
  logic                           skip;       // drop next valid instruction
  logic                           run;        // valid and not skipped
  logic [data_w-1:0]              opnd;       // immediate or Rr
  logic [data_w-1:0]              alu_y;
  logic                           alu_co;
  logic                           alu_z;
  logic                           skip_take;
  logic [data_w-1:0]              a_next;
  logic                           rf_we;
  logic [data_w-1:0]              rf_wdata;

  assign run  = decoded.valid && !skip;
  assign opnd = decoded.uses_reg ? rf[decoded.r] : decoded.imm;

  ////////////////////////////////////////////////////////////////////////////
  // ALU

  always_comb begin
    alu_co = 1'b0;
    case (decoded.op)
      andi:    alu_y = a & opnd;
      ori:     alu_y = a | opnd;
      xori:    alu_y = a ^ opnd;
      default: begin
        if (decoded.alu_sub) begin
          {alu_co, alu_y} = {1'b0, a} - {1'b0, opnd};   // co is borrow
        end else begin
          {alu_co, alu_y} = {1'b0, a} + {1'b0, opnd};
        end
      end
    endcase
  end

  assign alu_z     = (alu_y == '0);
  assign skip_take = (decoded.skip_on_carry && alu_co) ||
                     (decoded.skip_on_zero && alu_z);

  ////////////////////////////////////////////////////////////////////////////
  // write-back selection

  always_comb begin
    case (decoded.op)
      mvi_a:   a_next = decoded.imm;
      mov_a_r: a_next = opnd;
      in_pa:   a_next = pa;             // port sampled at execute
      default: a_next = alu_y;
    endcase
  end

  assign rf_we    = run && (decoded.op == mvi_r || decoded.op == mov_r_a);
  assign rf_wdata = (decoded.op == mov_r_a) ? a : decoded.imm;

  // jump request back to fetch and decode
  // a skipped jmp raises no request
  assign redirect = '{valid: run && (decoded.op == jmp), target: decoded.target};

  ////////////////////////////////////////////////////////////////////////////
  // architectural state

  always_ff @(posedge CLK) begin
    if (rst) begin
      a         <= '0;
      rf        <= '0;
      skip      <= 1'b0;
      pb        <= '0;
      pb_strobe <= 1'b0;
    end else begin
      pb_strobe <= 1'b0;

      // a valid slot either consumes the flag or sets it afresh
      if (decoded.valid) begin
        skip <= run && skip_take;
      end

      if (run && decoded.writes_a) begin
        a <= a_next;
      end

      if (rf_we) begin
        rf[decoded.r] <= rf_wdata;
      end

      if (run && (decoded.op == out_pb)) begin
        pb        <= a;
        pb_strobe <= 1'b1;              // one cycle per result
      end
    end
  end

endmodule

// File: hdl/instr_decode.sv
// instruction decoder with one register stage between fetch and execute
`timescale 1ns/1ps

module instr_decode
  import snd_pkg::*;
(
  input  logic      CLK,
  input  logic      rst,
  input  fetch_t    fetched,
  input  redirect_t redirect,
  output dec_t      decoded
);

  logic [op_w-1:0] op_field;
  dec_t            dec_d;     // decoded record for the word at fetch
  dec_t            dec_q;
  logic            dec_valid;

  assign op_field = fetched.word[op_lsb +: op_w];

  ////////////////////////////////////////////////////////////////////////////
  // field extraction and control bits

  always_comb begin
    dec_d        = '0;
    dec_d.valid  = fetched.valid;
    dec_d.r      = fetched.word[8 +: reg_aw];
    dec_d.imm    = fetched.word[data_w-1:0];
    dec_d.target = fetched.word[rom_aw-1:0];

    if (op_field > op_w'(jmp)) begin
      dec_d.op = nop;                       // unused encodings
    end else begin
      dec_d.op = op_e'(op_field);
    end

    case (dec_d.op)
      mvi_a, in_pa: begin
        dec_d.writes_a = 1'b1;
      end
      mov_a_r: begin
        dec_d.writes_a = 1'b1;
        dec_d.uses_reg = 1'b1;
      end
      adi: begin
        dec_d.writes_a      = 1'b1;
        dec_d.skip_on_carry = 1'b1;
      end
      sbi: begin
        dec_d.writes_a      = 1'b1;
        dec_d.alu_sub       = 1'b1;
        dec_d.skip_on_carry = 1'b1;         // carry out doubles as borrow
      end
      andi: begin
        dec_d.writes_a     = 1'b1;
        dec_d.skip_on_zero = 1'b1;
      end
      ori, xori: begin
        dec_d.writes_a = 1'b1;
      end
      add_r: begin
        dec_d.writes_a = 1'b1;
        dec_d.uses_reg = 1'b1;              // no skip test
      end
      default: begin
        dec_d.writes_a = 1'b0;              // register writes, port out, jmp
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // pipeline register

  always_ff @(posedge CLK) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= fetched.valid && !redirect.valid;  // younger word is dead
    end
  end

  always_ff @(posedge CLK) begin
    if (fetched.valid) begin
      dec_q <= dec_d;
    end
  end

  always_comb begin
    decoded       = dec_q;
    decoded.valid = dec_valid;
  end

endmodule

// File: hdl/prog_fetch.sv
// program ROM with its load port, program counter
// and jump redirect
`timescale 1ns/1ps

module prog_fetch
  import snd_pkg::*;
(
  input  logic               CLK,
  input  logic               rst,
  input  logic               prog_we,
  input  logic [rom_aw-1:0]  prog_addr,
  input  logic [instr_w-1:0] prog_data,
  input  redirect_t          redirect,
  output fetch_t             fetched
);

  logic [instr_w-1:0] rom [rom_depth];
  logic [rom_aw-1:0]  pc;         // address being read this cycle
  logic [rom_aw-1:0]  rd_pc;      // address of rd_word
  logic [instr_w-1:0] rd_word;
  logic               rd_valid;

  ////////////////////////////////////////////////////////////////////////////
  // program store

  always_ff @(posedge CLK) begin
    if (rst && prog_we) begin
      rom[prog_addr] <= prog_data;  // loads only while reset is held
    end
    rd_word <= rom[pc];             // registered read
    rd_pc   <= pc;
  end

  ////////////////////////////////////////////////////////////////////////////
  // program counter

  always_ff @(posedge CLK) begin
    if (rst) begin
      pc       <= '0;
      rd_valid <= 1'b0;
    end else if (redirect.valid) begin
      pc       <= redirect.target;
      rd_valid <= 1'b0;             // drop the word on the old path
    end else begin
      pc       <= pc + rom_aw'(1);  // wraps at 511
      rd_valid <= 1'b1;
    end
  end

  assign fetched = '{valid: rd_valid, pc: rd_pc, word: rd_word};

endmodule

// File: hdl/snd_pkg.sv
// widths, opcode enum and inter-stage records
// shared by the sound cpu pipeline
package snd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  localparam int instr_w   = 16;            // program word
  localparam int data_w    = 8;             // accumulator and registers
  localparam int rom_aw    = 9;             // 512-word program
  localparam int reg_aw    = 4;             // sixteen Rr
  localparam int op_w      = 4;
  localparam int op_lsb    = instr_w - op_w; // opcode sits in the top nibble
  localparam int rom_depth = 1 << rom_aw;
  localparam int reg_num   = 1 << reg_aw;

  ////////////////////////////////////////////////////////////////////////////
  // instruction word
  //
  // bits 15..12 opcode, 11..8 register index, 7..0 immediate
  // jmp takes its target from bits 8..0

  typedef enum logic [op_w-1:0] {
    nop     = 4'd0,
    mvi_a   = 4'd1,   // A <- n
    mvi_r   = 4'd2,   // Rr <- n
    mov_a_r = 4'd3,   // A <- Rr
    mov_r_a = 4'd4,   // Rr <- A
    adi     = 4'd5,   // skip on carry
    sbi     = 4'd6,   // skip on borrow
    andi    = 4'd7,   // skip on zero
    ori     = 4'd8,
    xori    = 4'd9,
    add_r   = 4'd10,  // A <- A + Rr
    in_pa   = 4'd11,
    out_pb  = 4'd12,
    jmp     = 4'd13
  } op_e;             // 14 and 15 fold to nop in decode

  ////////////////////////////////////////////////////////////////////////////
  // stage records

  // fetch to decode
  typedef struct packed {
    logic               valid;
    logic [rom_aw-1:0]  pc;
    logic [instr_w-1:0] word;
  } fetch_t;

  // decode to execute
  typedef struct packed {
    logic               valid;
    op_e                op;
    logic [reg_aw-1:0]  r;
    logic [data_w-1:0]  imm;
    logic [rom_aw-1:0]  target;
    logic               alu_sub;        // subtract instead of add
    logic               skip_on_carry;  // carry or borrow test
    logic               skip_on_zero;
    logic               writes_a;
    logic               uses_reg;       // ALU operand is Rr
  } dec_t;

  // execute back to fetch and decode
  typedef struct packed {
    logic              valid;
    logic [rom_aw-1:0] target;
  } redirect_t;

endpackage
